// ==== src/vga_bus_pkg.sv ====
package vga_bus_pkg;

  localparam int WB_DW = 32;
  localparam int WB_AW = 30; // word address, byte address bits 31:2
  localparam int WB_SW = WB_DW / 8;

  // master side of a classic cycle
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_SW-1:0] sel;
    logic [WB_DW-1:0] dat;
  } wb_req_t;

  // slave side, ack is a single cycle
  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

endpackage

// ==== src/vga_disp_pkg.sv ====
package vga_disp_pkg;

  localparam int BPP = 8;

  typedef struct packed {
    logic [BPP-1:0] r;
    logic [BPP-1:0] g;
    logic [BPP-1:0] b;
  } rgb_t;

  // code 3 is not named and behaves like MODE_OFF
  typedef enum logic [1:0] {
    MODE_MONO = 2'd0,
    MODE_13H  = 2'd1,
    MODE_OFF  = 2'd2
  } vga_mode_t;

  // 640x480 at 60 Hz
  localparam int H_VISIBLE_DEF = 640;
  localparam int H_FRONT_DEF   = 16;
  localparam int H_SYNC_DEF    = 96;
  localparam int H_BACK_DEF    = 48;
  localparam int V_VISIBLE_DEF = 480;
  localparam int V_FRONT_DEF   = 10;
  localparam int V_SYNC_DEF    = 2;
  localparam int V_BACK_DEF    = 33;

  localparam logic [1:0] REG_BASE   = 2'd0; // word index, byte address bits 3:2
  localparam logic [1:0] REG_MODE   = 2'd1;
  localparam logic [1:0] REG_STATUS = 2'd2;

  localparam int ST_UNDERRUN = 0;

  localparam rgb_t FG_MONO = '{r: '1, g: '1, b: '1};
  localparam rgb_t BG_MONO = '{r: '0, g: '0, b: '0};

endpackage

// ==== src/vga_regs.sv ====
`timescale 1ns/1ps

module vga_regs
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  vga_bus_pkg::wb_req_t          cfg_req_i,
  input  logic                          underrun_i,
  output vga_bus_pkg::wb_rsp_t          cfg_rsp_o,
  output vga_disp_pkg::vga_mode_t       mode_o,
  output logic [vga_bus_pkg::WB_AW-1:0] base_o
);

  typedef enum logic {SS_IDLE, SS_DONE} sstate_t;

  sstate_t                       sstate_q, sstate_d;
  logic [vga_bus_pkg::WB_DW-1:0] base_q, base_d;
  logic [1:0]                    mode_q, mode_d;
  logic                          underrun_q, underrun_d;
  logic [vga_bus_pkg::WB_DW-1:0] rdat_q, rdat_d;
  logic [vga_bus_pkg::WB_DW-1:0] wmask;
  logic [1:0]                    idx;

  assign idx = cfg_req_i.adr[1:0];

  always_comb
  begin
    for (int i = 0; i < vga_bus_pkg::WB_SW; i++)
      wmask[8*i +: 8] = {8{cfg_req_i.sel[i]}};
  end

  always_comb
  begin
    sstate_d   = sstate_q;
    base_d     = base_q;
    mode_d     = mode_q;
    underrun_d = underrun_q;
    rdat_d     = rdat_q;
    case (sstate_q)
      SS_IDLE:
        if (cfg_req_i.cyc && cfg_req_i.stb)
        begin
          sstate_d = SS_DONE;
          if (cfg_req_i.we)
          begin
            case (idx)
              vga_disp_pkg::REG_BASE:
                base_d = (base_q & ~wmask) | (cfg_req_i.dat & wmask);
              vga_disp_pkg::REG_MODE:
                if (cfg_req_i.sel[0])
                  mode_d = cfg_req_i.dat[1:0];
              vga_disp_pkg::REG_STATUS:
                if (cfg_req_i.sel[0] && cfg_req_i.dat[vga_disp_pkg::ST_UNDERRUN])
                  underrun_d = 1'b0; // write one to clear
              default: ;
            endcase
          end
          else
          begin
            rdat_d = '0;
            case (idx)
              vga_disp_pkg::REG_BASE:   rdat_d = base_q;
              vga_disp_pkg::REG_MODE:   rdat_d[1:0] = mode_q;
              vga_disp_pkg::REG_STATUS: rdat_d[vga_disp_pkg::ST_UNDERRUN] = underrun_q;
              default: ;
            endcase
          end
        end
      default: sstate_d = SS_IDLE;
    endcase
    if (underrun_i)
      underrun_d = 1'b1; // fresh pulse beats a clear
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      sstate_q   <= SS_IDLE;
      base_q     <= '0;
      mode_q     <= vga_disp_pkg::MODE_OFF;
      underrun_q <= 1'b0;
    end
    else
    begin
      sstate_q   <= sstate_d;
      base_q     <= base_d;
      mode_q     <= mode_d;
      underrun_q <= underrun_d;
    end
  end

  always_ff @(posedge clk_i)
    rdat_q <= rdat_d;

  assign cfg_rsp_o.ack = (sstate_q == SS_DONE);
  assign cfg_rsp_o.dat = rdat_q;
  assign mode_o        = vga_disp_pkg::vga_mode_t'(mode_q);
  assign base_o        = base_q[vga_bus_pkg::WB_AW-1:0];

  ack_single_a: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_rsp_o.ack |=> !cfg_rsp_o.ack);

endmodule

// ==== src/vga_crtc.sv ====
`timescale 1ns/1ps

module vga_crtc
#(
  parameter int H_VISIBLE = vga_disp_pkg::H_VISIBLE_DEF,
  parameter int H_FRONT   = vga_disp_pkg::H_FRONT_DEF,
  parameter int H_SYNC    = vga_disp_pkg::H_SYNC_DEF,
  parameter int H_BACK    = vga_disp_pkg::H_BACK_DEF,
  parameter int V_VISIBLE = vga_disp_pkg::V_VISIBLE_DEF,
  parameter int V_FRONT   = vga_disp_pkg::V_FRONT_DEF,
  parameter int V_SYNC    = vga_disp_pkg::V_SYNC_DEF,
  parameter int V_BACK    = vga_disp_pkg::V_BACK_DEF
)
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  vga_disp_pkg::vga_mode_t       mode_i,
  input  logic [vga_bus_pkg::WB_AW-1:0] base_i,
  input  vga_disp_pkg::rgb_t            mono_pix_i,
  input  vga_disp_pkg::rgb_t            h13_pix_i,
  input  vga_bus_pkg::wb_req_t          mono_req_i,
  input  vga_bus_pkg::wb_req_t          h13_req_i,
  output logic [15:0]                   x_o,
  output logic [15:0]                   y_o,
  output logic                          h_active_o,
  output logic                          v_active_o,
  output logic                          eol_o,
  output logic                          eos_o,
  output vga_disp_pkg::vga_mode_t       frame_mode_o,
  output logic [vga_bus_pkg::WB_AW-1:0] frame_base_o,
  output vga_bus_pkg::wb_req_t          mem_req_o,
  output vga_disp_pkg::rgb_t            rgb_o,
  output logic                          hs_o,
  output logic                          vs_o,
  output logic                          blank_n_o
);

  localparam int H_TOTAL  = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_0 = H_VISIBLE + H_FRONT;
  localparam int V_SYNC_0 = V_VISIBLE + V_FRONT;

  logic [15:0]                   h_q, v_q;
  vga_disp_pkg::vga_mode_t       mode_q;
  logic [vga_bus_pkg::WB_AW-1:0] base_q;
  vga_disp_pkg::rgb_t            pix;
  logic                          hs, vs, blank_n;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      h_q <= '0;
      v_q <= '0;
    end
    else if (h_q == 16'(H_TOTAL - 1))
    begin
      h_q <= '0;
      v_q <= (v_q == 16'(V_TOTAL - 1)) ? '0 : v_q + 16'd1;
    end
    else
      h_q <= h_q + 16'd1;
  end

  assign x_o        = h_q;
  assign y_o        = v_q;
  assign h_active_o = (h_q < 16'(H_VISIBLE));
  assign v_active_o = (v_q < 16'(V_VISIBLE));
  assign eol_o      = (h_q == 16'(H_VISIBLE - 1));
  assign eos_o      = (h_q == 16'(H_TOTAL - 1)) && (v_q == 16'(V_TOTAL - 1));
  assign hs = !((h_q >= 16'(H_SYNC_0)) && (h_q < 16'(H_SYNC_0 + H_SYNC)));
  assign vs = !((v_q >= 16'(V_SYNC_0)) && (v_q < 16'(V_SYNC_0 + V_SYNC)));
  assign blank_n = h_active_o & v_active_o;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      mode_q <= vga_disp_pkg::MODE_OFF;
      base_q <= '0;
    end
    else if (eos_o)
    begin
      mode_q <= mode_i;
      base_q <= base_i;
    end
  end

  // drivers see the new frame values already in the eos cycle
  assign frame_mode_o = eos_o ? mode_i : mode_q;
  assign frame_base_o = eos_o ? base_i : base_q;

  always_comb
  begin
    case (frame_mode_o)
      vga_disp_pkg::MODE_MONO:
      begin
        mem_req_o = mono_req_i;
        pix       = mono_pix_i;
      end
      vga_disp_pkg::MODE_13H:
      begin
        mem_req_o = h13_req_i;
        pix       = h13_pix_i;
      end
      default:
      begin
        mem_req_o = '0;
        pix       = '0; // off, sync keeps running
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      rgb_o     <= '0;
      hs_o      <= 1'b1;
      vs_o      <= 1'b1;
      blank_n_o <= 1'b0;
    end
    else
    begin
      rgb_o     <= blank_n ? pix : '0;
      hs_o      <= hs;
      vs_o      <= vs;
      blank_n_o <= blank_n;
    end
  end

  hs_width_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(hs_o) |-> (!hs_o) [*H_SYNC] ##1 hs_o);

endmodule

// ==== src/gm_mono.sv ====
`timescale 1ns/1ps

module gm_mono
#(
  parameter int H_VISIBLE = vga_disp_pkg::H_VISIBLE_DEF
)
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          en_i,
  input  logic [vga_bus_pkg::WB_AW-1:0] base_i,
  input  logic [15:0]                   x_i,
  input  logic                          h_active_i,
  input  logic                          v_active_i,
  input  logic                          eol_i,
  input  logic                          eos_i,
  input  vga_bus_pkg::wb_rsp_t          mem_rsp_i,
  output vga_bus_pkg::wb_req_t          mem_req_o,
  output vga_disp_pkg::rgb_t            pix_o,
  output logic                          underrun_o
);

  logic [vga_bus_pkg::WB_AW-1:0] adr_q;
  logic                          req_q, pend_q;
  logic [vga_bus_pkg::WB_DW-1:0] cur_q, nxt_q, word;
  logic                          cur_vld_q, nxt_vld_q, word_vld;
  logic                          ack, bound, fetch, start;

  assign ack   = req_q & mem_rsp_i.ack;
  assign bound = en_i & h_active_i & v_active_i & (x_i[4:0] == 5'd0); // word boundary
  // last word of a line fetches nothing, eol starts the next line
  assign fetch = bound & (x_i < 16'(H_VISIBLE - 32));
  assign start = en_i & ~req_q & (eos_i | (eol_i & v_active_i) | fetch | pend_q);
  assign underrun_o = bound & ~nxt_vld_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      adr_q     <= '0;
      req_q     <= 1'b0;
      pend_q    <= 1'b0;
      cur_vld_q <= 1'b0;
      nxt_vld_q <= 1'b0;
    end
    else
    begin
      if (eos_i & ~req_q)
        adr_q <= base_i;
      else if (ack)
        adr_q <= adr_q + 1'b1;
      if (~en_i | ack)
        req_q <= 1'b0;
      else if (start)
        req_q <= 1'b1;
      if (~en_i | eos_i | start)
        pend_q <= 1'b0;
      else if (fetch)
        pend_q <= 1'b1; // word still in flight, fetch once it lands
      if (bound)
      begin
        cur_vld_q <= nxt_vld_q;
        nxt_vld_q <= 1'b0;
      end
      if (ack)
        nxt_vld_q <= 1'b1;
      if (eos_i)
      begin
        cur_vld_q <= 1'b0;
        nxt_vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (bound)
      cur_q <= nxt_q;
    if (ack)
      nxt_q <= mem_rsp_i.dat;
  end

  // boundary pixel comes straight from the prefetch slot
  assign word     = (x_i[4:0] == 5'd0) ? nxt_q : cur_q;
  assign word_vld = (x_i[4:0] == 5'd0) ? nxt_vld_q : cur_vld_q;
  assign pix_o    = (word_vld && word[~x_i[4:0]]) ? vga_disp_pkg::FG_MONO
                                                  : vga_disp_pkg::BG_MONO;

  assign mem_req_o.cyc = req_q;
  assign mem_req_o.stb = req_q;
  assign mem_req_o.we  = 1'b0;
  assign mem_req_o.adr = adr_q;
  assign mem_req_o.sel = '1;
  assign mem_req_o.dat = '0;

  adr_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_o.stb && !mem_rsp_i.ack |=> $stable(mem_req_o.adr));

endmodule

// ==== src/gm_13h.sv ====
`timescale 1ns/1ps

module gm_13h
#(
  parameter int H_VISIBLE = vga_disp_pkg::H_VISIBLE_DEF
)
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          en_i,
  input  logic [vga_bus_pkg::WB_AW-1:0] base_i,
  input  logic [15:0]                   x_i,
  input  logic [15:0]                   y_i,
  input  logic                          h_active_i,
  input  logic                          v_active_i,
  input  logic                          eol_i,
  input  logic                          eos_i,
  input  vga_bus_pkg::wb_rsp_t          mem_rsp_i,
  output vga_bus_pkg::wb_req_t          mem_req_o,
  output vga_disp_pkg::rgb_t            pix_o,
  output logic                          underrun_o
);

  logic [vga_bus_pkg::WB_AW-1:0] adr_q, line_q;
  logic                          req_q;
  logic [vga_bus_pkg::WB_DW-1:0] cur_q, nxt_q, word;
  logic                          cur_vld_q, nxt_vld_q, word_vld;
  logic [7:0]                    pix_byte;
  logic                          ack, bound, line_go, start;

  assign ack     = req_q & mem_rsp_i.ack;
  assign bound   = en_i & h_active_i & v_active_i & (x_i[2:0] == 3'd0); // 4 pixels, doubled
  assign line_go = en_i & ~req_q & (eos_i | (eol_i & v_active_i));
  assign start   = line_go | (en_i & ~req_q & bound & (x_i < 16'(H_VISIBLE - 8)));
  assign underrun_o = bound & ~nxt_vld_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      adr_q     <= '0;
      line_q    <= '0;
      req_q     <= 1'b0;
      cur_vld_q <= 1'b0;
      nxt_vld_q <= 1'b0;
    end
    else
    begin
      if (line_go & eos_i)
      begin
        adr_q  <= base_i;
        line_q <= base_i;
      end
      else if (line_go & ~y_i[0])
        adr_q <= line_q;        // odd line repeats the even one
      else if (line_go)
        line_q <= adr_q;        // start of the next line pair
      else if (ack)
        adr_q <= adr_q + 1'b1;
      if (~en_i | ack)
        req_q <= 1'b0;
      else if (start)
        req_q <= 1'b1;
      if (bound)
      begin
        cur_vld_q <= nxt_vld_q;
        nxt_vld_q <= 1'b0;
      end
      if (ack)
        nxt_vld_q <= 1'b1;
      if (eos_i)
      begin
        cur_vld_q <= 1'b0;
        nxt_vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (bound)
      cur_q <= nxt_q;
    if (ack)
      nxt_q <= mem_rsp_i.dat;
  end

  assign word     = (x_i[2:0] == 3'd0) ? nxt_q : cur_q;
  assign word_vld = (x_i[2:0] == 3'd0) ? nxt_vld_q : cur_vld_q;
  assign pix_byte = word[{x_i[2:1], 3'b000} +: 8]; // low byte leftmost

  // rrrgggbb widened by bit repetition
  assign pix_o.r = word_vld ? {pix_byte[7:5], pix_byte[7:5], pix_byte[7:6]} : '0;
  assign pix_o.g = word_vld ? {pix_byte[4:2], pix_byte[4:2], pix_byte[4:3]} : '0;
  assign pix_o.b = word_vld ? {4{pix_byte[1:0]}} : '0;

  assign mem_req_o.cyc = req_q;
  assign mem_req_o.stb = req_q;
  assign mem_req_o.we  = 1'b0;
  assign mem_req_o.adr = adr_q;
  assign mem_req_o.sel = '1;
  assign mem_req_o.dat = '0;

endmodule

// ==== src/vga_master.sv ====
`timescale 1ns/1ps

module vga_master
#(
  parameter int H_VISIBLE = vga_disp_pkg::H_VISIBLE_DEF,
  parameter int H_FRONT   = vga_disp_pkg::H_FRONT_DEF,
  parameter int H_SYNC    = vga_disp_pkg::H_SYNC_DEF,
  parameter int H_BACK    = vga_disp_pkg::H_BACK_DEF,
  parameter int V_VISIBLE = vga_disp_pkg::V_VISIBLE_DEF,
  parameter int V_FRONT   = vga_disp_pkg::V_FRONT_DEF,
  parameter int V_SYNC    = vga_disp_pkg::V_SYNC_DEF,
  parameter int V_BACK    = vga_disp_pkg::V_BACK_DEF
)
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  vga_bus_pkg::wb_req_t cfg_req_i,
  output vga_bus_pkg::wb_rsp_t cfg_rsp_o,
  output vga_bus_pkg::wb_req_t mem_req_o,
  input  vga_bus_pkg::wb_rsp_t mem_rsp_i,
  output vga_disp_pkg::rgb_t   rgb_o,
  output logic                 hs_o,
  output logic                 vs_o,
  output logic                 blank_n_o
);

  vga_disp_pkg::vga_mode_t       mode, frame_mode;
  logic [vga_bus_pkg::WB_AW-1:0] base, frame_base;
  logic [15:0]                   x, y;
  logic                          h_active, v_active, eol, eos;
  vga_bus_pkg::wb_req_t          mono_req, h13_req;
  vga_disp_pkg::rgb_t            mono_pix, h13_pix;
  logic                          mono_ur, h13_ur, underrun;
  logic                          mono_en, h13_en;

  assign underrun = mono_ur | h13_ur;
  assign mono_en  = (frame_mode == vga_disp_pkg::MODE_MONO);
  assign h13_en   = (frame_mode == vga_disp_pkg::MODE_13H);

  vga_regs regs0 (
    .clk_i(clk_i), .rst_i(rst_i), .cfg_req_i(cfg_req_i), .underrun_i(underrun),
    .cfg_rsp_o(cfg_rsp_o), .mode_o(mode), .base_o(base));

  vga_crtc #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) crtc0 (
    .clk_i(clk_i), .rst_i(rst_i), .mode_i(mode), .base_i(base),
    .mono_pix_i(mono_pix), .h13_pix_i(h13_pix), .mono_req_i(mono_req), .h13_req_i(h13_req),
    .x_o(x), .y_o(y), .h_active_o(h_active), .v_active_o(v_active), .eol_o(eol), .eos_o(eos),
    .frame_mode_o(frame_mode), .frame_base_o(frame_base), .mem_req_o(mem_req_o),
    .rgb_o(rgb_o), .hs_o(hs_o), .vs_o(vs_o), .blank_n_o(blank_n_o));

  gm_mono #(.H_VISIBLE(H_VISIBLE)) mono0 (
    .clk_i(clk_i), .rst_i(rst_i), .en_i(mono_en), .base_i(frame_base), .x_i(x),
    .h_active_i(h_active), .v_active_i(v_active), .eol_i(eol), .eos_i(eos),
    .mem_rsp_i(mem_rsp_i), .mem_req_o(mono_req), .pix_o(mono_pix), .underrun_o(mono_ur));

  gm_13h #(.H_VISIBLE(H_VISIBLE)) h13_0 (
    .clk_i(clk_i), .rst_i(rst_i), .en_i(h13_en), .base_i(frame_base), .x_i(x), .y_i(y),
    .h_active_i(h_active), .v_active_i(v_active), .eol_i(eol), .eos_i(eos),
    .mem_rsp_i(mem_rsp_i), .mem_req_o(h13_req), .pix_o(h13_pix), .underrun_o(h13_ur));

endmodule

// ==== sim/vga_mem_model.sv ====
`timescale 1ns/1ps

module vga_mem_model
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  int                   lat_i,
  input  vga_bus_pkg::wb_req_t req_i,
  output vga_bus_pkg::wb_rsp_t rsp_o
);

  logic [vga_bus_pkg::WB_DW-1:0] mem [0:255];
  int                            cnt;
  integer                        seed;

  initial
  begin
    seed = 74515;
    for (int i = 0; i < 256; i++)
      mem[i] = $random(seed);
  end

  // ack after lat_i cycles of a held request, one cycle wide
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      cnt   <= 0;
      rsp_o <= '0;
    end
    else
    begin
      rsp_o.ack <= 1'b0;
      if (req_i.cyc && req_i.stb && !rsp_o.ack)
      begin
        if (cnt + 1 >= lat_i)
        begin
          rsp_o.ack <= 1'b1;
          rsp_o.dat <= mem[req_i.adr[7:0]];
          cnt       <= 0;
        end
        else
          cnt <= cnt + 1;
      end
      else
        cnt <= 0; // master dropped the cycle
    end
  end

endmodule

// ==== sim/tb_vga_master.sv ====
`timescale 1ns/1ps

module tb_vga_master;

  localparam int H_VIS   = 64;
  localparam int V_VIS   = 8;
  localparam int H_SYNC  = 8;
  localparam int LINE    = 96;
  localparam int FRAME   = 13 * LINE;
  localparam int TIMEOUT = 12 * FRAME;

  logic                    clk_i;
  logic                    rst_i;
  vga_bus_pkg::wb_req_t    cfg_req, mem_req;
  vga_bus_pkg::wb_rsp_t    cfg_rsp, mem_rsp;
  vga_disp_pkg::rgb_t      rgb;
  logic                    hs, vs, blank_n;
  int                      mem_lat;
  int                      cycles;
  vga_disp_pkg::rgb_t      frame_pix [0:H_VIS*V_VIS-1];
  logic [31:0]             rd;

  vga_master #(
    .H_VISIBLE(64), .H_FRONT(4), .H_SYNC(8), .H_BACK(20),
    .V_VISIBLE(8), .V_FRONT(1), .V_SYNC(2), .V_BACK(2)
  ) uut (
    .clk_i(clk_i), .rst_i(rst_i), .cfg_req_i(cfg_req), .cfg_rsp_o(cfg_rsp),
    .mem_req_o(mem_req), .mem_rsp_i(mem_rsp), .rgb_o(rgb), .hs_o(hs), .vs_o(vs),
    .blank_n_o(blank_n));

  vga_mem_model mem0 (.clk_i(clk_i), .rst_i(rst_i), .lat_i(mem_lat), .req_i(mem_req),
                      .rsp_o(mem_rsp));

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles >= TIMEOUT)
      abort_run("simulation hung, cycle limit reached");
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_rgb(input string name, input vga_disp_pkg::rgb_t got,
                           input vga_disp_pkg::rgb_t exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_mode(input string name, input vga_disp_pkg::vga_mode_t got,
                            input vga_disp_pkg::vga_mode_t exp);
    if (got !== exp)
      abort_run($sformatf("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp));
  endtask

  task automatic cfg_access(input logic we, input logic [1:0] idx, input logic [3:0] sel,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    int waited;
    cfg_req     = '0;
    cfg_req.cyc = 1'b1;
    cfg_req.stb = 1'b1;
    cfg_req.we  = we;
    cfg_req.adr = 30'(idx);
    cfg_req.sel = sel;
    cfg_req.dat = wdat;
    waited = 0;
    @(negedge clk_i);
    while (!cfg_rsp.ack)
    begin
      waited++;
      if (waited > 8)
        abort_run("config bus never acknowledged the request");
      @(negedge clk_i);
    end
    check_word("cfg ack cycle", waited + 2, 2); // counted from the first stb cycle
    rdat    = cfg_rsp.dat;
    cfg_req = '0;
    @(negedge clk_i);
  endtask

  task automatic cfg_write(input logic [1:0] idx, input logic [3:0] sel, input logic [31:0] d);
    logic [31:0] unused;
    cfg_access(1'b1, idx, sel, d, unused);
  endtask

  task automatic cfg_read(input logic [1:0] idx, output logic [31:0] d);
    cfg_access(1'b0, idx, 4'hf, '0, d);
  endtask

  function automatic vga_disp_pkg::rgb_t mono_px(input logic [31:0] w, input int k);
    return w[31-k] ? vga_disp_pkg::FG_MONO : vga_disp_pkg::BG_MONO;
  endfunction

  // repeat an n-bit field from its msb until 8 bits are filled
  function automatic logic [7:0] widen(input logic [7:0] f, input int n);
    logic [7:0] v;
    for (int i = 0; i < 8; i++)
      v[7-i] = f[n-1-(i % n)];
    return v;
  endfunction

  // rrrgggbb
  function automatic vga_disp_pkg::rgb_t expand_332(input logic [7:0] b);
    vga_disp_pkg::rgb_t p;
    p.r = widen(8'(b[7:5]), 3);
    p.g = widen(8'(b[4:2]), 3);
    p.b = widen(8'(b[1:0]), 2);
    return p;
  endfunction

  task automatic wait_frame_start();
    @(negedge clk_i);
    while (vs !== 1'b0)
      @(negedge clk_i);
    while (vs !== 1'b1)
      @(negedge clk_i);
  endtask

  task automatic skip_pixels(input int n, input logic want_black);
    int seen;
    seen = 0;
    while (seen < n)
    begin
      if (blank_n)
      begin
        seen++;
        if (want_black)
          check_rgb("rgb", rgb, '0);
      end
      @(negedge clk_i);
    end
  endtask

  task automatic grab_frame();
    int n;
    wait_frame_start();
    n = 0;
    while (n < H_VIS * V_VIS)
    begin
      if (blank_n)
      begin
        frame_pix[n] = rgb;
        n++;
      end
      @(negedge clk_i);
    end
  endtask

  task automatic test_registers();
    cfg_read(vga_disp_pkg::REG_MODE, rd);
    check_mode("mode after reset", vga_disp_pkg::vga_mode_t'(rd[1:0]), vga_disp_pkg::MODE_OFF);
    cfg_read(vga_disp_pkg::REG_BASE, rd);
    check_word("base after reset", rd, 32'h0);
    cfg_write(vga_disp_pkg::REG_BASE, 4'hf, 32'h1122_3344);
    cfg_read(vga_disp_pkg::REG_BASE, rd);
    check_word("base", rd, 32'h1122_3344);
    cfg_write(vga_disp_pkg::REG_BASE, 4'b0100, 32'haabb_ccdd);
    cfg_read(vga_disp_pkg::REG_BASE, rd);
    check_word("base merged", rd, 32'h11bb_3344);
    cfg_read(2'd3, rd);
    check_word("unmapped index", rd, 32'h0);
  endtask

  task automatic test_off_timing();
    int hs_run, bl_run, vs_low, lines;
    hs_run = 0;
    bl_run = 0;
    vs_low = 0;
    lines  = 0;
    wait_frame_start();
    for (int i = 0; i < FRAME; i++)
    begin
      check_rgb("rgb in off mode", rgb, '0);
      if (!hs)
        hs_run++;
      else if (hs_run != 0)
      begin
        check_word("hs low width", hs_run, H_SYNC);
        hs_run = 0;
      end
      if (blank_n)
        bl_run++;
      else if (bl_run != 0)
      begin
        check_word("blank_n high width", bl_run, H_VIS);
        bl_run = 0;
        lines++;
      end
      if (!vs)
        vs_low++;
      @(negedge clk_i);
    end
    check_word("visible lines", lines, V_VIS);
    check_word("vs low cycles", vs_low, 2 * LINE);
  endtask

  task automatic test_mode_switch();
    logic [31:0] w;
    cfg_write(vga_disp_pkg::REG_BASE, 4'hf, 32'h40);
    wait_frame_start();
    skip_pixels(3 * H_VIS, 1'b1);
    cfg_write(vga_disp_pkg::REG_MODE, 4'h1, 32'(vga_disp_pkg::MODE_MONO));
    while (vs !== 1'b0)
    begin
      if (blank_n)
        check_rgb("rgb before frame switch", rgb, '0);
      @(negedge clk_i);
    end
    cfg_read(vga_disp_pkg::REG_MODE, rd);
    check_mode("mode", vga_disp_pkg::vga_mode_t'(rd[1:0]), vga_disp_pkg::MODE_MONO);
    grab_frame();
    // line 0 starts without its first word, rows hold two words each
    for (int y = 1; y < V_VIS; y++)
      for (int k = 0; k < H_VIS; k++)
      begin
        w = mem0.mem[8'(32'h40 + 2 * y + k / 32)];
        check_rgb($sformatf("mono rgb y%0d x%0d", y, k), frame_pix[y*H_VIS+k], mono_px(w, k % 32));
      end
  endtask

  task automatic test_13h_frame();
    logic [31:0] w;
    cfg_write(vga_disp_pkg::REG_BASE, 4'hf, 32'h80);
    cfg_write(vga_disp_pkg::REG_MODE, 4'h1, 32'(vga_disp_pkg::MODE_13H));
    grab_frame();
    // odd rows read the same words as the row above
    for (int y = 1; y < V_VIS; y++)
      for (int k = 0; k < H_VIS; k++)
      begin
        w = mem0.mem[8'(32'h80 + 8 * (y / 2) + k / 8)];
        check_rgb($sformatf("13h rgb y%0d x%0d", y, k), frame_pix[y*H_VIS+k],
                  expand_332(w[8*((k/2)%4) +: 8]));
      end
  endtask

  task automatic status_after_frame(input int lat, input logic [31:0] exp);
    mem_lat = lat;
    wait_frame_start();
    skip_pixels(2 * H_VIS, 1'b0); // line 0 always starts without its first word
    cfg_write(vga_disp_pkg::REG_STATUS, 4'h1, 32'h1);
    skip_pixels((V_VIS - 2) * H_VIS - 4, 1'b0);
    cfg_read(vga_disp_pkg::REG_STATUS, rd);
    check_word("status underrun", rd, exp);
  endtask

  task automatic test_underrun();
    status_after_frame(12, 32'h1);
    status_after_frame(1, 32'h0);
  endtask

  initial
  begin
    clk_i   = 1'b0;
    rst_i   = 1'b1;
    cfg_req = '0;
    mem_lat = 1;
    cycles  = 0;
    repeat (2) @(negedge clk_i);
    check_word("blank_n in reset", blank_n, 0);
    check_word("hs in reset", hs, 1);
    check_word("vs in reset", vs, 1);
    check_word("mem cyc in reset", mem_req.cyc, 0);
    check_word("mem stb in reset", mem_req.stb, 0);
    check_word("cfg ack in reset", cfg_rsp.ack, 0);
    rst_i = 1'b0;
    @(negedge clk_i);
    test_registers();
    test_off_timing();
    test_mode_switch();
    test_13h_frame();
    test_underrun();
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
src/vga_bus_pkg.sv
src/vga_disp_pkg.sv
src/vga_regs.sv
src/vga_crtc.sv
src/gm_mono.sv
src/gm_13h.sv
src/vga_master.sv
sim/vga_mem_model.sv
sim/tb_vga_master.sv
